//--- all.f
design/noc_pkg.sv
design/flit_source.sv
design/flit_fifo.sv
design/flit_sink.sv
design/ring_system.sv
verif/tb_clock_gen.sv
verif/tb_ring_system.sv

//--- design/flit_fifo.sv
// Link buffer FIFO
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire                 clk,
   input  wire                 rst,
   input  wire noc_pkg::flit_t in_flit,
   input  wire                 in_last,
   input  wire                 in_valid,
   output logic                in_ready,
   output noc_pkg::flit_t      out_flit,
   output logic                out_last,
   output logic                out_valid,
   input  wire                 out_ready
);

   import noc_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_MAX  = PTR_W'(FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

   // Storage, flit and last flag side by side
   flit_t                 flit_mem [FIFO_DEPTH];
   logic [FIFO_DEPTH-1:0] last_mem;

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // Number of flits held
   logic [CNT_W-1:0] fill;
   logic             wr_en;
   logic             rd_en;

   assign in_ready  = (fill != CNT_FULL);
   assign out_valid = (fill != '0);
   assign wr_en     = in_valid & in_ready;
   assign rd_en     = out_valid & out_ready;

   // Head of queue straight out of storage
   assign out_flit = flit_mem[rd_ptr];
   assign out_last = last_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         flit_mem[wr_ptr] <= in_flit;
         last_mem[wr_ptr] <= in_last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_MAX) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_MAX) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves fill unchanged
         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // Count never runs past full or wraps below empty
   assert property (@(posedge clk) disable iff (rst)
      fill <= CNT_FULL)
   else $error("flit_fifo fill count out of range");

   // Pointers meet only when empty or full
   assert property (@(posedge clk) disable iff (rst)
      (wr_ptr == rd_ptr) == (fill == '0 || fill == CNT_FULL))
   else $error("flit_fifo pointers disagree with fill count");

endmodule

`default_nettype wire

//--- design/flit_sink.sv
// Ring receiving adapter
`timescale 1ns/1ps
`default_nettype none

module flit_sink #(
   parameter int TILE_ID   = 0,
   parameter int NUM_TILES = 4,
   parameter int PKT_LEN   = 4
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      start,
   input  wire noc_pkg::pkt_count_t num_packets,
   input  wire                      stall,
   input  wire noc_pkg::flit_t      in_flit,
   input  wire                      in_last,
   input  wire                      in_valid,
   output logic                     in_ready,
   output noc_pkg::pkt_count_t      pkt_count,
   output noc_pkg::pkt_count_t      err_count,
   output logic                     term
);

   import noc_pkg::*;

   localparam int IDX_W = $clog2(PKT_LEN);
   localparam tile_id_t OWN_ID  = tile_id_t'(TILE_ID);
   // Upstream neighbour in the ring
   localparam tile_id_t PREV_ID = tile_id_t'((TILE_ID + NUM_TILES - 1) % NUM_TILES);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PKT_LEN - 1);

   sink_state_t      state;
   pkt_count_t       pkt_target;
   pkt_count_t       pkt_next;
   // Faults gathered so far in this packet
   pkt_count_t       pkt_errs;
   // Faults of the flit now on the link
   pkt_count_t       flit_errs;
   logic [IDX_W-1:0] flit_idx;
   seq_t             exp_seq;
   // Field views of the incoming flit
   tile_id_t         rx_dest;
   tile_id_t         rx_src;
   tile_id_t         rx_pld_src;
   logic [15:0]      rx_len;
   seq_t             rx_seq;
   logic             last_ok;
   logic             xfer;

   assign rx_dest    = in_flit[HDR_DEST_MSB -: $bits(tile_id_t)];
   assign rx_src     = in_flit[HDR_SRC_MSB -: $bits(tile_id_t)];
   assign rx_len     = in_flit[HDR_LEN_MSB:0];
   assign rx_pld_src = in_flit[PLD_SRC_MSB -: $bits(tile_id_t)];
   assign rx_seq     = in_flit[PLD_SEQ_MSB:0];

   // Accept only inside a run and when not stalled
   assign in_ready = !stall && (state == HEADER || state == PAYLOAD);
   assign xfer     = in_valid & in_ready;
   assign term     = (state == DONE);
   assign pkt_next = pkt_count + 1'b1;
   // last expected exactly at the final position
   assign last_ok  = (in_last == (flit_idx == LAST_IDX));

   always_comb begin
      flit_errs = '0;
      if (state == HEADER) begin
         if (rx_dest != OWN_ID || rx_src != PREV_ID) begin
            flit_errs = flit_errs + 1'b1;
         end
         if (rx_len != 16'(PKT_LEN)) begin
            flit_errs = flit_errs + 1'b1;
         end
      end else if (rx_pld_src != PREV_ID || rx_seq != exp_seq) begin
         // Stream from upstream broke
         flit_errs = flit_errs + 1'b1;
      end
      if (!last_ok) begin
         flit_errs = flit_errs + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         pkt_target <= '0;
         pkt_count  <= '0;
         err_count  <= '0;
         pkt_errs   <= '0;
         flit_idx   <= '0;
         exp_seq    <= '0;
      end else if (start) begin
         pkt_target <= num_packets;
         pkt_count  <= '0;
         err_count  <= '0;
         pkt_errs   <= '0;
         flit_idx   <= '0;
         state      <= (num_packets == '0) ? DONE : HEADER;
      end else if (xfer) begin
         // Resync on the received number so one slip counts once
         if (state == PAYLOAD) begin
            exp_seq <= rx_seq + 1'b1;
         end
         if (in_last) begin
            pkt_count <= pkt_next;
            err_count <= err_count + pkt_errs + flit_errs;
            pkt_errs  <= '0;
            flit_idx  <= '0;
            state     <= (pkt_next == pkt_target) ? DONE : HEADER;
         end else begin
            pkt_errs <= pkt_errs + flit_errs;
            // Saturate while a missing last is outstanding
            if (flit_idx != LAST_IDX) begin
               flit_idx <= flit_idx + 1'b1;
            end
            state <= PAYLOAD;
         end
      end
   end

   // Never more packets than requested
   assert property (@(posedge clk) disable iff (rst)
      pkt_count <= pkt_target)
   else $error("flit_sink %0d counted past num_packets", TILE_ID);

endmodule

`default_nettype wire

//--- design/flit_source.sv
// Ring traffic source
`timescale 1ns/1ps
`default_nettype none

module flit_source #(
   parameter int TILE_ID   = 0,
   parameter int NUM_TILES = 4,
   parameter int PKT_LEN   = 4
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      start,
   input  wire noc_pkg::pkt_count_t num_packets,
   output noc_pkg::flit_t           out_flit,
   output logic                     out_last,
   output logic                     out_valid,
   input  wire                      out_ready
);

   import noc_pkg::*;

   localparam int IDX_W = $clog2(PKT_LEN);
   localparam tile_id_t SRC_ID = tile_id_t'(TILE_ID);
   // Next tile around the ring
   localparam tile_id_t DEST_ID = tile_id_t'((TILE_ID + 1) % NUM_TILES);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PKT_LEN - 1);

   // Flit position inside the current packet
   logic [IDX_W-1:0] flit_idx;
   pkt_count_t       pkt_sent;
   pkt_count_t       pkt_target;
   pkt_count_t       sent_next;
   // Payload counter, kept across runs
   seq_t             seq;
   logic             active;
   logic             xfer;

   assign xfer      = out_valid & out_ready;
   assign sent_next = pkt_sent + 1'b1;

   // Valid comes from state only, never from ready
   assign out_valid = active;
   assign out_last  = (flit_idx == LAST_IDX);

   // Flit contents follow the registered position
   always_comb begin
      out_flit = '0;
      if (flit_idx == '0) begin
         // Header
         out_flit[HDR_DEST_MSB -: $bits(tile_id_t)] = DEST_ID;
         out_flit[HDR_SRC_MSB -: $bits(tile_id_t)]  = SRC_ID;
         out_flit[HDR_LEN_MSB:0]                    = 16'(PKT_LEN);
      end else begin
         // Payload
         out_flit[PLD_SRC_MSB -: $bits(tile_id_t)] = SRC_ID;
         out_flit[PLD_SEQ_MSB:0]                   = seq;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active     <= 1'b0;
         flit_idx   <= '0;
         pkt_sent   <= '0;
         pkt_target <= '0;
         seq        <= '0;
      end else if (start) begin
         // New run, zero packets means stay quiet
         active     <= (num_packets != '0);
         flit_idx   <= '0;
         pkt_sent   <= '0;
         pkt_target <= num_packets;
      end else if (xfer) begin
         if (flit_idx != '0) begin
            seq <= seq + 1'b1;
         end
         if (out_last) begin
            flit_idx <= '0;
            pkt_sent <= sent_next;
            // Final packet of the run
            if (sent_next == pkt_target) begin
               active <= 1'b0;
            end
         end else begin
            flit_idx <= flit_idx + 1'b1;
         end
      end
   end

   // Offered flit holds until the FIFO takes it
   assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready && !start |=>
         out_valid && $stable(out_flit) && $stable(out_last))
   else $error("flit_source %0d changed an offered flit before transfer", TILE_ID);

endmodule

`default_nettype wire

//--- design/noc_pkg.sv
// NoC ring shared types
`default_nettype none

package noc_pkg;

   // One word on a link
   typedef logic [31:0] flit_t;

   // Tile identifier
   typedef logic [7:0] tile_id_t;

   // Requested or received packet count
   typedef logic [15:0] pkt_count_t;

   // Running payload sequence number
   typedef logic [23:0] seq_t;

   // Header flit layout
   // Destination tile in the top byte
   localparam int HDR_DEST_MSB = 31;
   // Source tile below it
   localparam int HDR_SRC_MSB  = 23;
   // Packet length in flits, header included
   localparam int HDR_LEN_MSB  = 15;

   // Payload flit layout
   // Sending tile in the top byte
   localparam int PLD_SRC_MSB  = 31;
   // Sequence number fills the rest
   localparam int PLD_SEQ_MSB  = 23;

   // Receiving adapter FSM
   typedef enum logic [1:0] {
      IDLE,
      HEADER,
      PAYLOAD,
      DONE
   } sink_state_t;

endpackage

`default_nettype wire

//--- design/ring_system.sv
// Ring of traffic tiles
`timescale 1ns/1ps
`default_nettype none

module ring_system #(
   parameter int NUM_TILES  = 4,
   parameter int PKT_LEN    = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  wire                                      clk,
   input  wire                                      rst,
   input  wire                                      start,
   input  wire noc_pkg::pkt_count_t                 num_packets,
   input  wire [NUM_TILES-1:0]                      stall,
   output logic                                     done,
   // Receive link of each tile
   output wire noc_pkg::flit_t [NUM_TILES-1:0]      rx_flit,
   output wire [NUM_TILES-1:0]                      rx_last,
   output wire [NUM_TILES-1:0]                      rx_valid,
   output wire [NUM_TILES-1:0]                      rx_ready,
   // Per-tile sink results
   output wire noc_pkg::pkt_count_t [NUM_TILES-1:0] pkt_count,
   output wire noc_pkg::pkt_count_t [NUM_TILES-1:0] err_count
);

   import noc_pkg::*;

   // Source to FIFO link of each tile
   wire flit_t [NUM_TILES-1:0] src_flit;
   wire [NUM_TILES-1:0]        src_last;
   wire [NUM_TILES-1:0]        src_valid;
   wire [NUM_TILES-1:0]        src_ready;
   wire [NUM_TILES-1:0]        term;

   // Global termination once every sink is done
   assign done = &term;

   for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile
      // FIFO t feeds the sink of the next tile
      localparam int NEXT = (t + 1) % NUM_TILES;

      flit_source #(
         .TILE_ID   (t),
         .NUM_TILES (NUM_TILES),
         .PKT_LEN   (PKT_LEN)
      ) u_source (
         .clk         (clk),
         .rst         (rst),
         .start       (start),
         .num_packets (num_packets),
         .out_flit    (src_flit[t]),
         .out_last    (src_last[t]),
         .out_valid   (src_valid[t]),
         .out_ready   (src_ready[t])
      );

      flit_fifo #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_fifo (
         .clk       (clk),
         .rst       (rst),
         .in_flit   (src_flit[t]),
         .in_last   (src_last[t]),
         .in_valid  (src_valid[t]),
         .in_ready  (src_ready[t]),
         .out_flit  (rx_flit[NEXT]),
         .out_last  (rx_last[NEXT]),
         .out_valid (rx_valid[NEXT]),
         .out_ready (rx_ready[NEXT])
      );

      flit_sink #(
         .TILE_ID   (t),
         .NUM_TILES (NUM_TILES),
         .PKT_LEN   (PKT_LEN)
      ) u_sink (
         .clk         (clk),
         .rst         (rst),
         .start       (start),
         .num_packets (num_packets),
         .stall       (stall[t]),
         .in_flit     (rx_flit[t]),
         .in_last     (rx_last[t]),
         .in_valid    (rx_valid[t]),
         .in_ready    (rx_ready[t]),
         .pkt_count   (pkt_count[t]),
         .err_count   (err_count[t]),
         .term        (term[t])
      );
   end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter real PERIOD_NS = 100.0
) (
   output logic clk
);

   // Starts low, first rising edge after half a period
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_ring_system.sv
// NoC ring testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ring_system;

   import noc_pkg::*;

   // Must match the ring_system defaults
   localparam int NUM_TILES = 4;
   localparam int PKT_LEN   = 4;

   localparam int RST_CYCLES   = 16;
   localparam int IDLE_CYCLES  = 20;
   // Packets per run, in the order the runs happen
   localparam int NUM_RUNS     = 5;
   localparam int TOTAL_PKTS   = 3 + 3 + 0 + 2 + 5;
   // Worst slowdown expected from random stall
   localparam int STALL_FACTOR = 4;
   localparam int RUN_MARGIN   = 40;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + IDLE_CYCLES +
      TOTAL_PKTS * PKT_LEN * STALL_FACTOR + NUM_RUNS * RUN_MARGIN;

   logic                         clk;
   logic                         rst;
   logic                         start;
   pkt_count_t                   num_packets;
   logic [NUM_TILES-1:0]         stall = '0;
   wire                          done;
   wire flit_t [NUM_TILES-1:0]      rx_flit;
   wire [NUM_TILES-1:0]             rx_last;
   wire [NUM_TILES-1:0]             rx_valid;
   wire [NUM_TILES-1:0]             rx_ready;
   wire pkt_count_t [NUM_TILES-1:0] pkt_count;
   wire pkt_count_t [NUM_TILES-1:0] err_count;

   int     errors   = 0;
   int     timeouts = 0;
   string  test_name = "reset";
   integer seed = 32'hcc06;
   logic   [31:0] rand_word;
   // Phase flags seen by the assertions
   logic   stall_random = 1'b0;
   logic   idle_window  = 1'b0;
   logic   empty_window = 1'b0;

   tb_clock_gen u_clock (
      .clk (clk)
   );

   ring_system DUT (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .num_packets (num_packets),
      .stall       (stall),
      .done        (done),
      .rx_flit     (rx_flit),
      .rx_last     (rx_last),
      .rx_valid    (rx_valid),
      .rx_ready    (rx_ready),
      .pkt_count   (pkt_count),
      .err_count   (err_count)
   );

   // Random back-pressure per sink
   always @(posedge clk) begin
      rand_word = $random(seed);
      if (stall_random) begin
         stall <= rand_word[NUM_TILES-1:0];
      end else begin
         stall <= '0;
      end
   end

   // Nothing moves before the first start
   assert property (@(posedge clk) disable iff (rst)
      idle_window |-> rx_valid == '0 && !done)
   else begin
      errors++;
      $display("Link activity or done seen before any start");
   end

   // Termination holds until the next run
   assert property (@(posedge clk) disable iff (rst)
      done && !start |=> done)
   else begin
      errors++;
      $display("done dropped without a new start");
   end

   // A run with packets clears termination
   assert property (@(posedge clk) disable iff (rst)
      start && num_packets != '0 |=> !done)
   else begin
      errors++;
      $display("done stayed high after a start with packets");
   end

   // Zero packets means a silent ring
   assert property (@(posedge clk) disable iff (rst)
      empty_window |-> (rx_valid & rx_ready) == '0)
   else begin
      errors++;
      $display("Flit transferred during a run with zero packets");
   end

   for (genvar t = 0; t < NUM_TILES; t++) begin : gen_link
      localparam tile_id_t OWN_ID  = tile_id_t'(t);
      localparam tile_id_t PREV_ID = tile_id_t'((t + NUM_TILES - 1) % NUM_TILES);

      // Reference stream of this link
      int    pos;
      seq_t  exp_seq;
      flit_t exp_flit;
      logic  exp_last;

      // Seq keeps counting across runs, only reset clears it
      always @(posedge clk) begin
         if (rst) begin
            pos     <= 0;
            exp_seq <= '0;
         end else if (rx_valid[t] && rx_ready[t]) begin
            if (pos != 0) begin
               exp_seq <= exp_seq + 1'b1;
            end
            pos <= (pos == PKT_LEN - 1) ? 0 : pos + 1;
         end
      end

      always_comb begin
         if (pos == 0) begin
            // Header of dest, src and length
            exp_flit = {OWN_ID, PREV_ID, 16'(PKT_LEN)};
         end else begin
            exp_flit = {PREV_ID, exp_seq};
         end
         exp_last = (pos == PKT_LEN - 1);
      end

      assert property (@(posedge clk) disable iff (rst)
         rx_valid[t] && rx_ready[t] |-> rx_flit[t] == exp_flit)
      else begin
         errors++;
         $display("FAILED %s link %0d flit expected %h actual %h",
                  test_name, t, $sampled(exp_flit), $sampled(rx_flit[t]));
      end

      assert property (@(posedge clk) disable iff (rst)
         rx_valid[t] && rx_ready[t] |-> rx_last[t] == exp_last)
      else begin
         errors++;
         $display("FAILED %s link %0d last expected %b actual %b",
                  test_name, t, $sampled(exp_last), $sampled(rx_last[t]));
      end

      // Offered flit waits unchanged through back-pressure
      assert property (@(posedge clk) disable iff (rst)
         rx_valid[t] && !rx_ready[t] |=>
            rx_valid[t] && $stable(rx_flit[t]) && $stable(rx_last[t]))
      else begin
         errors++;
         $display("Link %0d dropped or changed a flit while stalled", t);
      end

      // Stalled sink refuses flits
      assert property (@(posedge clk) disable iff (rst)
         stall[t] |-> !rx_ready[t])
      else begin
         errors++;
         $display("Link %0d ready high while its sink was stalled", t);
      end

      assert property (@(posedge clk) disable iff (rst)
         idle_window |-> pkt_count[t] == '0 && err_count[t] == '0)
      else begin
         errors++;
         $display("FAILED %s tile %0d counts expected 0/0 actual %0d/%0d",
                  test_name, t, $sampled(pkt_count[t]), $sampled(err_count[t]));
      end

      // Counts settled whenever the ring reports done
      assert property (@(posedge clk) disable iff (rst)
         done && !start |-> pkt_count[t] == num_packets)
      else begin
         errors++;
         $display("FAILED %s tile %0d pkt_count expected %0d actual %0d",
                  test_name, t, $sampled(num_packets), $sampled(pkt_count[t]));
      end

      assert property (@(posedge clk) disable iff (rst)
         done && !start |-> err_count[t] == '0)
      else begin
         errors++;
         $display("FAILED %s tile %0d err_count expected 0 actual %0d",
                  test_name, t, $sampled(err_count[t]));
      end
   end

   // One start pulse, then wait for done with a bound
   task automatic run_packets(input string name, input int pkts, input logic random);
      int limit;
      int waited;
      limit  = pkts * PKT_LEN * STALL_FACTOR + RUN_MARGIN;
      waited = 0;
      test_name = name;
      @(posedge clk);
      stall_random <= random;
      empty_window <= (pkts == 0);
      start        <= 1'b1;
      num_packets  <= pkt_count_t'(pkts);
      @(posedge clk);
      start <= 1'b0;
      // Old done is gone after this edge
      @(negedge clk);
      while (!done && waited < limit) begin
         @(negedge clk);
         waited++;
      end
      if (!done) begin
         errors++;
         timeouts++;
         $display("Test %s did not reach done within %0d cycles", name, limit);
      end
      @(posedge clk);
      stall_random <= 1'b0;
      empty_window <= 1'b0;
      repeat (4) @(posedge clk);
   endtask

   initial begin
      rst         = 1'b1;
      start       = 1'b0;
      num_packets = '0;
      repeat (RST_CYCLES) @(posedge clk);
      rst         <= 1'b0;
      idle_window <= 1'b1;
      repeat (IDLE_CYCLES) @(posedge clk);
      idle_window <= 1'b0;

      run_packets("run_basic", 3, 1'b0);
      run_packets("run_stall", 3, 1'b1);
      run_packets("run_empty", 0, 1'b0);
      // Back to back with new counts, seq carries on
      run_packets("run_b2b_short", 2, 1'b0);
      run_packets("run_b2b_long", 5, 1'b1);

      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Hard bound on the whole run
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      errors++;
      timeouts++;
      $display("Watchdog expired after %0d cycles before the tests finished",
               WATCHDOG_CYCLES);
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire
